/* ahb_cache_top.f */
src/ahb_cache_pkg.sv
src/cfg_regs.sv
src/cpu_req_gen.sv
src/read_cache.sv
src/pattern_mem.sv
src/read_checker.sv
src/ahb_cache_top.sv
verification/tb_ahb_cache_top.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the cache testbench with Verilator.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f ahb_cache_top.f \
    --top-module tb_ahb_cache_top -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

echo "Simulation finished without failure"
exit 0

/* src/ahb_cache_pkg.sv */
package ahb_cache_pkg;

    localparam logic [31:0] BASE_ADDR   = 32'h0000_0A00;
    localparam int          NUM_LINES   = 16;
    localparam int          MEM_LATENCY = 4;
    localparam int          HIST_DEPTH  = 8;
    localparam logic [15:0] LFSR_TAPS   = 16'hB400;

    // Register map.
    localparam logic [2:0] REG_CTRL   = 3'd0;
    localparam logic [2:0] REG_PERIOD = 3'd1;
    localparam logic [2:0] REG_SEED   = 3'd2;
    localparam logic [2:0] REG_COUNT  = 3'd3;
    localparam logic [2:0] REG_HITS   = 3'd4;
    localparam logic [2:0] REG_MISSES = 3'd5;
    localparam logic [2:0] REG_ERRORS = 3'd6;
    localparam logic [2:0] REG_STATUS = 3'd7;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } trans_t;

    // Same word, seen raw or split for the cache lookup.
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [25:0] tag;
            logic [3:0]  index;
            logic [1:0]  offset;
        } f;
    } cache_addr_t;

    function automatic logic [31:0] pattern_data(input logic [31:0] addr);
        return {addr[15:0] ^ 16'hA5C3, addr[15:0]};
    endfunction

endpackage

/* src/ahb_cache_top.sv */
`timescale 1ns/1ps

module ahb_cache_top import ahb_cache_pkg::*; (
    input  logic        cpu_intf,
    input  logic        arst_n,
    input  logic        cfg_we,
    input  logic [2:0]  cfg_addr,
    input  logic [31:0] cfg_wdata,
    output logic [31:0] cfg_rdata,
    output logic [31:0] haddr,
    output trans_t      htrans,
    output logic [31:0] hrdata,
    output logic        hready
);

    logic        enable;
    logic        flush;
    logic        seed_load;
    logic [7:0]  period;
    logic [15:0] seed;
    logic [15:0] req_count;
    logic [15:0] hit_count;
    logic [15:0] miss_count;
    logic [15:0] error_count;
    logic        done;
    logic        hwrite;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        mem_valid;
    logic [31:0] mem_rdata;

    cfg_regs i_cfg_regs (
        .cpu_intf(cpu_intf), .arst_n(arst_n), .cfg_we(cfg_we), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata), .enable(enable), .flush(flush),
        .seed_load(seed_load), .period(period), .seed(seed), .req_count(req_count),
        .hit_count(hit_count), .miss_count(miss_count), .error_count(error_count),
        .done(done)
    );

    cpu_req_gen i_cpu_req_gen (
        .cpu_intf(cpu_intf), .arst_n(arst_n), .enable(enable), .seed_load(seed_load),
        .flush(flush), .period(period), .seed(seed), .req_count(req_count),
        .hready(hready), .haddr(haddr), .htrans(htrans), .hwrite(hwrite), .done(done)
    );

    read_cache i_read_cache (
        .cpu_intf(cpu_intf), .arst_n(arst_n), .flush(flush), .haddr(haddr),
        .htrans(htrans), .hwrite(hwrite), .hrdata(hrdata), .hready(hready),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_valid(mem_valid),
        .mem_rdata(mem_rdata), .hit_count(hit_count), .miss_count(miss_count)
    );

    pattern_mem i_pattern_mem (
        .cpu_intf(cpu_intf), .arst_n(arst_n), .mem_req(mem_req), .mem_addr(mem_addr),
        .mem_valid(mem_valid), .mem_rdata(mem_rdata)
    );

    read_checker i_read_checker (
        .cpu_intf(cpu_intf), .arst_n(arst_n), .haddr(haddr), .htrans(htrans),
        .hready(hready), .hrdata(hrdata), .error_count(error_count)
    );

endmodule

/* src/cfg_regs.sv */
`timescale 1ns/1ps

module cfg_regs import ahb_cache_pkg::*; (
    input  logic        cpu_intf,
    input  logic        arst_n,
    input  logic        cfg_we,
    input  logic [2:0]  cfg_addr,
    input  logic [31:0] cfg_wdata,
    output logic [31:0] cfg_rdata,
    output logic        enable,
    output logic        flush,
    output logic        seed_load,
    output logic [7:0]  period,
    output logic [15:0] seed,
    output logic [15:0] req_count,
    input  logic [15:0] hit_count,
    input  logic [15:0] miss_count,
    input  logic [15:0] error_count,
    input  logic        done
);

    always_ff @(posedge cpu_intf or negedge arst_n) begin
        if (!arst_n) begin
            enable    <= 1'b0;
            flush     <= 1'b0;
            seed_load <= 1'b0;
            period    <= '0;
            seed      <= '0;
            req_count <= '0;
        end else begin
            // Pulses last a single cycle.
            flush     <= cfg_we && (cfg_addr == REG_CTRL) && cfg_wdata[1];
            seed_load <= cfg_we && (cfg_addr == REG_SEED);
            if (cfg_we) begin
                case (cfg_addr)
                    REG_CTRL:   enable    <= cfg_wdata[0];
                    REG_PERIOD: period    <= cfg_wdata[7:0];
                    REG_SEED:   seed      <= cfg_wdata[15:0];
                    REG_COUNT:  req_count <= cfg_wdata[15:0];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            REG_CTRL:   cfg_rdata = {31'd0, enable};
            REG_PERIOD: cfg_rdata = {24'd0, period};
            REG_SEED:   cfg_rdata = {16'd0, seed};
            REG_COUNT:  cfg_rdata = {16'd0, req_count};
            REG_HITS:   cfg_rdata = {16'd0, hit_count};
            REG_MISSES: cfg_rdata = {16'd0, miss_count};
            REG_ERRORS: cfg_rdata = {16'd0, error_count};
            REG_STATUS: cfg_rdata = {31'd0, done};
            default:    cfg_rdata = '0;
        endcase
    end

endmodule

/* src/cpu_req_gen.sv */
`timescale 1ns/1ps

module cpu_req_gen import ahb_cache_pkg::*; (
    input  logic        cpu_intf,
    input  logic        arst_n,
    input  logic        enable,
    input  logic        seed_load,
    input  logic        flush,
    input  logic [7:0]  period,
    input  logic [15:0] seed,
    input  logic [15:0] req_count,
    input  logic        hready,
    output logic [31:0] haddr,
    output trans_t      htrans,
    output logic        hwrite,
    output logic        done
);

    logic [15:0] lfsr;
    logic [15:0] lfsr_next;
    logic [7:0]  cnt;
    logic [15:0] sent;
    logic        dpend;
    logic        pending;
    logic        run;
    logic        issue;
    logic        reuse;
    logic        push;
    cache_addr_t next_addr;
    logic [31:0] hist [HIST_DEPTH];
    logic [$clog2(HIST_DEPTH):0]   hist_fill;
    logic [$clog2(HIST_DEPTH)-1:0] hist_sel;

    assign hwrite = 1'b0;

    // Galois step, taken once per request.
    assign lfsr_next = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    assign hist_sel  = lfsr[3:1];
    assign reuse     = lfsr[0] && ({1'b0, hist_sel} < hist_fill);

    always_comb begin
        if (reuse) begin
            next_addr.raw = hist[hist_sel];
        end else begin
            next_addr.raw = BASE_ADDR + {24'd0, lfsr[7:2], 2'b00};
        end
    end

    assign pending = (htrans == NONSEQ) || dpend;
    assign run     = enable && (sent < req_count);
    assign issue   = run && !pending && (cnt == period - 8'd1);
    assign push    = issue && !reuse && (hist_fill < HIST_DEPTH);

    always_ff @(posedge cpu_intf or negedge arst_n) begin
        if (!arst_n) begin
            lfsr      <= '0;
            cnt       <= '0;
            sent      <= '0;
            htrans    <= IDLE;
            haddr     <= '0;
            dpend     <= 1'b0;
            done      <= 1'b0;
            hist_fill <= '0;
        end else begin
            if (seed_load) begin
                lfsr <= seed;
                sent <= '0;
                cnt  <= '0;
                done <= 1'b0;
            end else if (issue) begin
                lfsr   <= lfsr_next;
                sent   <= sent + 16'd1;
                cnt    <= '0;
                htrans <= NONSEQ;
                haddr  <= next_addr.raw;
            end else if (run && (cnt != period - 8'd1)) begin
                cnt <= cnt + 8'd1;
            end
            // Data phase ends at the first later edge with hready high.
            if (dpend && hready) begin
                dpend <= 1'b0;
                if ((sent == req_count) && !seed_load) begin
                    done <= 1'b1;
                end
            end
            if ((htrans == NONSEQ) && hready) begin
                htrans <= IDLE;
                dpend  <= 1'b1;
            end
            if (flush) begin
                hist_fill <= '0;
            end else if (push) begin
                hist_fill <= hist_fill + 1'b1;
            end
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (push) begin
            hist[hist_fill[$clog2(HIST_DEPTH)-1:0]] <= next_addr.raw;
        end
    end

endmodule

/* src/pattern_mem.sv */
`timescale 1ns/1ps

module pattern_mem import ahb_cache_pkg::*; (
    input  logic        cpu_intf,
    input  logic        arst_n,
    input  logic        mem_req,
    input  logic [31:0] mem_addr,
    output logic        mem_valid,
    output logic [31:0] mem_rdata
);

    logic [MEM_LATENCY-1:0] vld_pipe;
    logic [31:0]            addr_pipe [MEM_LATENCY];

    always_ff @(posedge cpu_intf or negedge arst_n) begin
        if (!arst_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[MEM_LATENCY-2:0], mem_req};
        end
    end

    // Address rides alongside its valid bit.
    always_ff @(posedge cpu_intf) begin
        addr_pipe[0] <= mem_addr;
        for (int i = 1; i < MEM_LATENCY; i++) begin
            addr_pipe[i] <= addr_pipe[i-1];
        end
    end

    assign mem_valid = vld_pipe[MEM_LATENCY-1];
    assign mem_rdata = pattern_data(addr_pipe[MEM_LATENCY-1]);

endmodule

/* src/read_cache.sv */
`timescale 1ns/1ps

module read_cache import ahb_cache_pkg::*; (
    input  logic        cpu_intf,
    input  logic        arst_n,
    input  logic        flush,
    input  logic [31:0] haddr,
    input  trans_t      htrans,
    input  logic        hwrite,
    output logic [31:0] hrdata,
    output logic        hready,
    output logic        mem_req,
    output logic [31:0] mem_addr,
    input  logic        mem_valid,
    input  logic [31:0] mem_rdata,
    output logic [15:0] hit_count,
    output logic [15:0] miss_count
);

    logic [31:0]          line_data [NUM_LINES];
    logic [25:0]          line_tag  [NUM_LINES];
    logic [NUM_LINES-1:0] line_valid;
    cache_addr_t          cap;
    logic                 dphase;
    logic                 fetching;
    logic                 accept;
    logic                 line_hit;
    logic                 hit_now;
    logic                 fill;

    // Only reads are served.
    assign accept = hready && !hwrite && ((htrans == NONSEQ) || (htrans == SEQ));

    assign line_hit = line_valid[cap.f.index] && (line_tag[cap.f.index] == cap.f.tag);
    assign hit_now  = dphase && !fetching && line_hit;
    assign fill     = fetching && mem_valid;

    // Stall through a miss until the fetched word arrives.
    assign hready = !dphase || hit_now || fill;
    assign hrdata = fetching ? mem_rdata : line_data[cap.f.index];

    assign mem_req  = dphase && !fetching && !line_hit;
    assign mem_addr = {cap.f.tag, cap.f.index, 2'b00};

    always_ff @(posedge cpu_intf or negedge arst_n) begin
        if (!arst_n) begin
            dphase     <= 1'b0;
            fetching   <= 1'b0;
            line_valid <= '0;
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            if (hready) begin
                dphase <= accept;
            end
            if (mem_req) begin
                fetching <= 1'b1;
            end else if (fill) begin
                fetching <= 1'b0;
            end
            if (hit_now) begin
                hit_count <= hit_count + 16'd1;
            end
            if (fill) begin
                miss_count <= miss_count + 16'd1;
            end
            if (flush) begin
                line_valid <= '0;
            end else if (fill) begin
                line_valid[cap.f.index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (accept) begin
            cap.raw <= haddr;
        end
        // Line takes the word on the same edge the CPU does.
        if (fill) begin
            line_data[cap.f.index] <= mem_rdata;
            line_tag[cap.f.index]  <= cap.f.tag;
        end
    end

endmodule

/* src/read_checker.sv */
`timescale 1ns/1ps

module read_checker import ahb_cache_pkg::*; (
    input  logic        cpu_intf,
    input  logic        arst_n,
    input  logic [31:0] haddr,
    input  trans_t      htrans,
    input  logic        hready,
    input  logic [31:0] hrdata,
    output logic [15:0] error_count
);

    logic [31:0] exp_addr;
    logic        dpend;
    logic        err_flag;

    always_ff @(posedge cpu_intf or negedge arst_n) begin
        if (!arst_n) begin
            dpend       <= 1'b0;
            err_flag    <= 1'b0;
            error_count <= '0;
        end else begin
            err_flag <= dpend && hready && (hrdata != pattern_data(exp_addr));
            if (hready) begin
                dpend <= (htrans == NONSEQ);
            end
            // Counted one cycle after the compare.
            if (err_flag) begin
                error_count <= error_count + 16'd1;
            end
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (hready && (htrans == NONSEQ)) begin
            exp_addr <= haddr;
        end
    end

endmodule

/* verification/ahb_cache_golden.txt */
# Columns, all hex: W reg data | A count addr ... | E hits misses errors
# W writes a register, A queues expected request addresses, E waits for done and checks counters.
W 1 0000000c
W 3 0000000c
A c ae0 a70 a38 a9c a4c a9c a70 a4c ac4 a60 ae0 a58
W 2 0000ace1
W 0 00000001
E 3 9 0
# Flush and rerun with a new seed; the counters keep accumulating.
W 0 00000002
A c a70 a38 a9c a4c a4c a38 a68 ab4 ad8 ad8 a74 ab4
W 2 00005a70
W 0 00000001
E 6 12 0

/* verification/tb_ahb_cache_top.sv */
`timescale 1ns/1ps

module tb_ahb_cache_top import ahb_cache_pkg::*; ();

    logic        cpu_intf;
    logic        arst_n;
    logic        cfg_we;
    logic [2:0]  cfg_addr;
    logic [31:0] cfg_wdata;
    logic [31:0] cfg_rdata;
    logic [31:0] haddr;
    trans_t      htrans;
    logic [31:0] hrdata;
    logic        hready;

    logic [7:0]  cmd_kind [$];
    logic [31:0] cmd_a [$];
    logic [31:0] cmd_b [$];
    logic [31:0] cmd_c [$];
    logic [31:0] gold_addr_q [$];
    logic [31:0] exp_addr_q [$];
    int          watchdog_limit;
    logic        limit_ready;
    int unsigned rand_seed;

    // Reference tag model of the cache.
    logic [NUM_LINES-1:0] model_valid;
    logic [25:0]          model_tag [NUM_LINES];
    logic [31:0]          model_hits;
    logic [31:0]          model_misses;
    logic [31:0]          cur_addr;
    logic                 cur_hit;
    logic                 stalled;
    logic                 in_dphase;

    ahb_cache_top i_ahb_cache_top (
        .cpu_intf(cpu_intf), .arst_n(arst_n), .cfg_we(cfg_we), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata), .haddr(haddr), .htrans(htrans),
        .hrdata(hrdata), .hready(hready)
    );

    always #20 cpu_intf = ~cpu_intf;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "Run stopped at the first failed check.");
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Error: %s is 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_trans(input string name, input trans_t got, input trans_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Error: %s is 0x%01h, expected 0x%01h", name, got, exp));
        end
    endtask

    // Upper half is the low address half XOR A5C3.
    function automatic logic [31:0] pattern_word(input logic [31:0] addr);
        return {addr[15:0] ^ 16'hA5C3, addr[15:0]};
    endfunction

    task automatic reg_write(input logic [2:0] a, input logic [31:0] d);
        @(negedge cpu_intf);
        cfg_we    = 1'b1;
        cfg_addr  = a;
        cfg_wdata = d;
        if ((a == REG_CTRL) && d[1]) begin
            model_valid = '0;
        end
        @(negedge cpu_intf);
        cfg_we = 1'b0;
        repeat ($urandom_range(3)) @(negedge cpu_intf);
    endtask

    task automatic reg_read(input logic [2:0] a, output logic [31:0] d);
        @(negedge cpu_intf);
        cfg_addr = a;
        @(negedge cpu_intf);
        d = cfg_rdata;
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        int          cnt;
        int          cur_period;
        int          cur_count;
        logic [63:0] tok;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        string       rest;
        fd = $fopen("verification/ahb_cache_golden.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open verification/ahb_cache_golden.txt.");
        end
        cur_period = 0;
        cur_count = 0;
        watchdog_limit = 20;
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == {56'd0, "#"}) begin
                n = $fgets(rest, fd);
            end else if (tok == {56'd0, "W"}) begin
                n = $fscanf(fd, "%h %h", a, b);
                if (n != 2) abort_run("A register write line in the golden file is malformed.");
                if (a == 32'(REG_PERIOD)) cur_period = int'(b);
                if (a == 32'(REG_COUNT)) cur_count = int'(b);
                watchdog_limit += 8;
                cmd_kind.push_back("W");
                cmd_a.push_back(a);
                cmd_b.push_back(b);
                cmd_c.push_back('0);
            end else if (tok == {56'd0, "A"}) begin
                n = $fscanf(fd, "%h", cnt);
                for (int k = 0; k < cnt; k++) begin
                    n = $fscanf(fd, "%h", a);
                    gold_addr_q.push_back(a);
                end
                cmd_kind.push_back("A");
                cmd_a.push_back(32'(cnt));
                cmd_b.push_back('0);
                cmd_c.push_back('0);
            end else if (tok == {56'd0, "E"}) begin
                n = $fscanf(fd, "%h %h %h", a, b, c);
                if (n != 3) abort_run("A counter line in the golden file is malformed.");
                watchdog_limit += cur_count * (cur_period + MEM_LATENCY + 4) + 200;
                cmd_kind.push_back("E");
                cmd_a.push_back(a);
                cmd_b.push_back(b);
                cmd_c.push_back(c);
            end else begin
                abort_run("The golden file holds an unknown command.");
            end
        end
        $fclose(fd);
    endtask

    task automatic accept_request();
        if (exp_addr_q.size() == 0) begin
            abort_run($sformatf("Request to 0x%08h lies beyond the golden sequence.", haddr));
        end
        if ((haddr < BASE_ADDR) || (haddr >= BASE_ADDR + 32'd256) || (haddr[1:0] != 2'b00)) begin
            abort_run($sformatf("Request to 0x%08h is outside the window or unaligned.", haddr));
        end
        check_word("haddr", haddr, exp_addr_q.pop_front());
        cur_addr  = haddr;
        cur_hit   = model_valid[haddr[5:2]] && (model_tag[haddr[5:2]] == haddr[31:6]);
        stalled   = 1'b0;
        in_dphase = 1'b1;
    endtask

    task automatic finish_dphase();
        check_word("hrdata", hrdata, pattern_word(cur_addr));
        if (cur_hit && stalled) begin
            abort_run($sformatf("Read of 0x%08h should hit but hready went low.", cur_addr));
        end
        if (!cur_hit && !stalled) begin
            abort_run($sformatf("Read of 0x%08h should miss but never stalled.", cur_addr));
        end
        if (cur_hit) begin
            model_hits = model_hits + 32'd1;
        end else begin
            model_misses = model_misses + 32'd1;
            model_valid[cur_addr[5:2]] = 1'b1;
            model_tag[cur_addr[5:2]]   = cur_addr[31:6];
        end
        in_dphase = 1'b0;
    endtask

    // Bus values seen here hold through the next rising edge.
    always @(negedge cpu_intf) begin
        if (arst_n && in_dphase) begin
            check_trans("htrans", htrans, IDLE);
            if (hready) begin
                finish_dphase();
            end else begin
                stalled = 1'b1;
            end
        end
        if (arst_n && (htrans == NONSEQ) && hready) begin
            accept_request();
        end
    end

    task automatic check_reset_state();
        logic [31:0] d;
        @(negedge cpu_intf);
        check_trans("htrans", htrans, IDLE);
        check_word("hready", {31'd0, hready}, 32'd1);
        reg_read(REG_HITS, d);
        check_word("HITS", d, 32'd0);
        reg_read(REG_MISSES, d);
        check_word("MISSES", d, 32'd0);
        reg_read(REG_ERRORS, d);
        check_word("ERRORS", d, 32'd0);
        reg_read(REG_STATUS, d);
        check_word("STATUS", d, 32'd0);
    endtask

    task automatic check_run(input logic [31:0] hits, input logic [31:0] misses,
                             input logic [31:0] errors);
        logic [31:0] d;
        @(negedge cpu_intf);
        cfg_addr = REG_STATUS;
        do @(negedge cpu_intf); while (cfg_rdata[0] !== 1'b1);
        // Error counter lags the last compare by a cycle.
        repeat (2) @(negedge cpu_intf);
        if (in_dphase || (exp_addr_q.size() != 0)) begin
            abort_run("done rose before every golden request was served.");
        end
        reg_read(REG_HITS, d);
        check_word("HITS", d, hits);
        check_word("HITS against model", d, model_hits);
        reg_read(REG_MISSES, d);
        check_word("MISSES", d, misses);
        check_word("MISSES against model", d, model_misses);
        reg_read(REG_ERRORS, d);
        check_word("ERRORS", d, errors);
        check_word("ERRORS", d, 32'd0);
    endtask

    task automatic run_golden();
        for (int i = 0; i < cmd_kind.size(); i++) begin
            if (cmd_kind[i] == "W") begin
                reg_write(cmd_a[i][2:0], cmd_b[i]);
            end else if (cmd_kind[i] == "A") begin
                repeat (cmd_a[i]) begin
                    exp_addr_q.push_back(gold_addr_q.pop_front());
                end
            end else begin
                check_run(cmd_a[i], cmd_b[i], cmd_c[i]);
            end
        end
    endtask

    initial begin
        wait (limit_ready);
        repeat (watchdog_limit) @(posedge cpu_intf);
        abort_run($sformatf("Timeout: done never rose within %0d cycles.", watchdog_limit));
    end

    initial begin
        cpu_intf     = 1'b0;
        arst_n       = 1'b0;
        cfg_we       = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        model_valid  = '0;
        model_hits   = '0;
        model_misses = '0;
        cur_addr     = '0;
        cur_hit      = 1'b0;
        stalled      = 1'b0;
        in_dphase    = 1'b0;
        limit_ready  = 1'b0;
        rand_seed    = $urandom(32'hfce28233);
        load_golden();
        limit_ready = 1'b1;
        repeat (8) @(negedge cpu_intf);
        arst_n = 1'b1;
        check_reset_state();
        run_golden();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
